/* rtl/pinmux_pkg.sv */
// Register map, bus word types and PWM types, imported by the pinmux RTL and its testbench
`default_nettype none

package pinmux_pkg;

  // --------------------------------------------------------------------------
  // Register bus types
  // --------------------------------------------------------------------------
  typedef logic [7:0]  reg_addr_t;   // Byte address
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_be_t;     // One enable per byte lane

  // Ports A to D, port A in the low byte
  typedef logic [31:0] port_word_t;

  // --------------------------------------------------------------------------
  // Tick and PWM types
  // --------------------------------------------------------------------------
  typedef logic [15:0] pwm_count_t;  // Duration in millisecond ticks
  typedef logic [9:0]  us_div_t;     // Clocks per microsecond, minus one

  typedef enum logic [1:0] {
    PWM_IDLE,
    PWM_HIGH,
    PWM_LOW
  } pwm_phase_e;

  localparam int PWM_NUM = 6;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------
  localparam reg_addr_t ADDR_GPIO_OUT = 8'h00;
  localparam reg_addr_t ADDR_GPIO_DIR = 8'h04;  // 1 means output
  localparam reg_addr_t ADDR_FUNC_SEL = 8'h08;  // PWM enables low, UART enable above
  localparam reg_addr_t ADDR_GPIO_IN  = 8'h0C;  // Read only
  localparam reg_addr_t ADDR_US_DIV   = 8'h10;
  localparam reg_addr_t ADDR_PWM_BASE = 8'h20;  // One word per channel, high:low

  // UART enable position in FUNC_SEL
  localparam int FUNC_UART_BIT = 8;

endpackage

`default_nettype wire

/* rtl/pad_map_pkg.sv */
// Pad count and the pad assignment of every port bit and pin function, imported by the pin mux
`default_nettype none

package pad_map_pkg;

  // Digital pads 0 to 23 of the 28-pin part
  localparam int PAD_NUM = 24;

  typedef logic [PAD_NUM-1:0] pad_vec_t;

  // Port bit without a pad
  localparam int PAD_NONE = -1;

  // --------------------------------------------------------------------------
  // Port bit to pad table indexed by the bit in the port word
  // --------------------------------------------------------------------------
  localparam int PORT_PAD [32] = '{
    // Port A is not pinned out
    PAD_NONE, PAD_NONE, PAD_NONE, PAD_NONE,
    PAD_NONE, PAD_NONE, PAD_NONE, PAD_NONE,
    // Port B0 to B7
    11, 12, 13, 14,
    15, 16,  6,  7,
    // Port C0 to C7 where C7 has no pin
    18, 19, 20, 21,
    22, 23,  0, PAD_NONE,
    // Port D0 to D7
     1,  2,  3,  4,
     5,  8,  9, 10
  };
  // Pad 17 is left without a port bit

  // --------------------------------------------------------------------------
  // Pin functions
  // --------------------------------------------------------------------------
  // PWM 0 to 5 on D3, D5, D6, B1, B2, B3
  localparam int PWM_PAD [6] = '{4, 8, 9, 12, 13, 14};

  localparam int UART_RXD_PAD = 1;  // Shares D0
  localparam int UART_TXD_PAD = 2;  // Shares D1

endpackage

`default_nettype wire

/* rtl/pinmux_cfg_if.sv */
// Configuration bundle from the register bank to the PWM, port and pad mux blocks
`timescale 1ns/100ps
`default_nettype none

interface pinmux_cfg_if;
  import pinmux_pkg::*;

  // Port registers
  port_word_t gpio_out;
  port_word_t gpio_dir;

  // Function select
  logic [PWM_NUM-1:0] pwm_enb;
  logic               uart_enb;

  // Tick divider and PWM durations
  us_div_t    us_div;
  pwm_count_t pwm_high [PWM_NUM];
  pwm_count_t pwm_low  [PWM_NUM];

  // Register bank owns every field
  modport regs (output gpio_out, gpio_dir, pwm_enb, uart_enb, us_div, pwm_high, pwm_low);

  modport pwm  (input pwm_enb, us_div, pwm_high, pwm_low);
  modport port (input gpio_out, gpio_dir);
  modport mux  (input pwm_enb, uart_enb);

endinterface

`default_nettype wire

/* rtl/pinmux_regs.sv */
// Pin mux register bank on the strobe and acknowledge bus, drives the configuration interface
`timescale 1ns/100ps
`default_nettype none

module pinmux_regs (
  input  logic                  mclk_i,
  input  logic                  arst_n_i,
  input  logic                  reg_cs_i,
  input  logic                  reg_wr_i,
  input  pinmux_pkg::reg_addr_t reg_addr_i,
  input  pinmux_pkg::reg_data_t reg_wdata_i,
  input  pinmux_pkg::reg_be_t   reg_be_i,
  output pinmux_pkg::reg_data_t reg_rdata_o,
  output logic                  reg_ack_o,
  input  pinmux_pkg::port_word_t gpio_in_i,
  pinmux_cfg_if.regs            cfg
);
  import pinmux_pkg::*;

  reg_data_t  rd_word;
  reg_data_t  wr_word;
  reg_data_t  func_word;
  logic [2:0] pwm_idx;
  logic       pwm_hit;
  logic       wr_en;
  logic       rd_en;

  // Keep old bytes where the lane is off
  function automatic reg_data_t be_merge(reg_data_t old_v, reg_data_t new_v, reg_be_t be);
    reg_data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  // PWM block sits on a 32-byte boundary
  assign pwm_idx = reg_addr_i[4:2];
  assign pwm_hit = (reg_addr_i[7:5] == ADDR_PWM_BASE[7:5]) &&
                   (reg_addr_i[1:0] == 2'b00) && (pwm_idx < PWM_NUM);

  // First cycle of an access captures read data, ack cycle commits the write
  assign rd_en = reg_cs_i & ~reg_ack_o;
  assign wr_en = reg_cs_i & reg_wr_i & reg_ack_o;

  // Function select as seen on the bus
  always_comb begin
    func_word = '0;
    func_word[PWM_NUM-1:0] = cfg.pwm_enb;
    func_word[FUNC_UART_BIT] = cfg.uart_enb;
  end

  // Read mux with unmapped addresses reading zero
  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      ADDR_GPIO_OUT: rd_word = cfg.gpio_out;
      ADDR_GPIO_DIR: rd_word = cfg.gpio_dir;
      ADDR_FUNC_SEL: rd_word = func_word;
      ADDR_GPIO_IN:  rd_word = gpio_in_i;
      ADDR_US_DIV:   rd_word = reg_data_t'(cfg.us_div);
      default: begin
        if (pwm_hit) begin
          rd_word = {cfg.pwm_high[pwm_idx], cfg.pwm_low[pwm_idx]};
        end
      end
    endcase
  end

  // Current value with the enabled bytes replaced
  assign wr_word = be_merge(rd_word, reg_wdata_i, reg_be_i);

  // --------------------------------------------------------------------------
  // Writable registers
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg.gpio_out <= '0;
      cfg.gpio_dir <= '0;
      cfg.pwm_enb  <= '0;
      cfg.uart_enb <= 1'b0;
      cfg.us_div   <= '0;
      for (int i = 0; i < PWM_NUM; i++) begin
        cfg.pwm_high[i] <= '0;
        cfg.pwm_low[i]  <= '0;
      end
    end else if (wr_en) begin
      case (reg_addr_i)
        ADDR_GPIO_OUT: cfg.gpio_out <= wr_word;
        ADDR_GPIO_DIR: cfg.gpio_dir <= wr_word;
        ADDR_FUNC_SEL: begin
          cfg.pwm_enb  <= wr_word[PWM_NUM-1:0];
          cfg.uart_enb <= wr_word[FUNC_UART_BIT];
        end
        ADDR_US_DIV:   cfg.us_div <= wr_word[$bits(us_div_t)-1:0];
        default: begin
          // GPIO_IN and holes fall through here and are dropped
          if (pwm_hit) begin
            cfg.pwm_high[pwm_idx] <= wr_word[31:16];
            cfg.pwm_low[pwm_idx]  <= wr_word[15:0];
          end
        end
      endcase
    end
  end

  // Ack one cycle after the strobe, then low for a cycle
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_ack_o <= 1'b0;
    end else begin
      reg_ack_o <= rd_en;
    end
  end

  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_rdata_o <= '0;
    end else if (rd_en) begin
      reg_rdata_o <= rd_word;
    end
  end

  // Master sees a single-cycle acknowledge per access
  a_ack_pulse: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    reg_ack_o |=> !reg_ack_o);

endmodule

`default_nettype wire

/* rtl/tick_gen.sv */
// Programmable microsecond tick and derived millisecond tick for the PWM bank
`timescale 1ns/100ps
`default_nettype none

module tick_gen #(
  parameter int US_PER_MS = 1000
) (
  input  logic                mclk_i,
  input  logic                arst_n_i,
  input  pinmux_pkg::us_div_t us_div_i,
  output logic                us_tick_o,
  output logic                ms_tick_o
);
  import pinmux_pkg::*;

  localparam int MS_W = (US_PER_MS > 1) ? $clog2(US_PER_MS) : 1;

  us_div_t         div_cnt;
  logic [MS_W-1:0] us_cnt;
  logic            us_wrap;

  // Divider wraps every us_div+1 clocks
  assign us_wrap = (div_cnt >= us_div_i);

  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_cnt   <= '0;
      us_cnt    <= '0;
      us_tick_o <= 1'b0;
      ms_tick_o <= 1'b0;
    end else begin
      us_tick_o <= us_wrap;
      ms_tick_o <= 1'b0;
      if (us_wrap) begin
        div_cnt <= '0;
        // Count microseconds only on the divider wrap
        if (us_cnt == MS_W'(US_PER_MS - 1)) begin
          us_cnt    <= '0;
          ms_tick_o <= 1'b1;
        end else begin
          us_cnt <= us_cnt + 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  a_ms_on_us: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
    ms_tick_o |-> us_tick_o);

endmodule

`default_nettype wire

/* rtl/pwm_bank.sv */
// Bank of PWM waveform generators timed in millisecond ticks, one output per channel
`timescale 1ns/100ps
`default_nettype none

module pwm_bank #(
  parameter int US_PER_MS = 1000,
  parameter int PWM_NUM_P = pinmux_pkg::PWM_NUM
) (
  input  logic                 mclk_i,
  input  logic                 arst_n_i,
  pinmux_cfg_if.pwm            cfg,
  output logic [PWM_NUM_P-1:0] pwm_wave_o
);
  import pinmux_pkg::*;

  logic ms_tick;

  // Shared timebase for all channels
  tick_gen #(.US_PER_MS(US_PER_MS)) u_tick_gen (
    .mclk_i    (mclk_i),
    .arst_n_i  (arst_n_i),
    .us_div_i  (cfg.us_div),
    .us_tick_o (),
    .ms_tick_o (ms_tick)
  );

  for (genvar i = 0; i < PWM_NUM_P; i++) begin : g_ch
    pwm_phase_e phase;
    pwm_count_t cnt;
    pwm_count_t high_last;
    pwm_count_t low_last;

    // Last tick index of each phase where zero length runs as one tick
    assign high_last = (cfg.pwm_high[i] == '0) ? '0 : cfg.pwm_high[i] - 1'b1;
    assign low_last  = (cfg.pwm_low[i] == '0) ? '0 : cfg.pwm_low[i] - 1'b1;

    always_ff @(posedge mclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        phase <= PWM_IDLE;
        cnt   <= '0;
      end else if (!cfg.pwm_enb[i]) begin
        phase <= PWM_IDLE;
        cnt   <= '0;
      end else if (ms_tick) begin
        case (phase)
          // Start on a tick so the first high phase is full length
          PWM_IDLE: begin
            phase <= PWM_HIGH;
            cnt   <= '0;
          end
          PWM_HIGH: begin
            if (cnt >= high_last) begin
              phase <= PWM_LOW;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          PWM_LOW: begin
            if (cnt >= low_last) begin
              phase <= PWM_HIGH;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          default: phase <= PWM_IDLE;
        endcase
      end
    end

    assign pwm_wave_o[i] = (phase == PWM_HIGH);

    a_off_low: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
      !cfg.pwm_enb[i] |=> !pwm_wave_o[i]);
  end

endmodule

`default_nettype wire

/* rtl/gpio_port.sv */
// GPIO port word logic, input synchronizer and output drive and enable toward the pad mux
`timescale 1ns/100ps
`default_nettype none

module gpio_port (
  input  logic                   mclk_i,
  input  logic                   arst_n_i,
  pinmux_cfg_if.port             cfg,
  input  pinmux_pkg::port_word_t port_pad_in_i,
  output pinmux_pkg::port_word_t port_sync_o,
  output pinmux_pkg::port_word_t port_drive_o,
  output pinmux_pkg::port_word_t port_oe_o
);
  import pinmux_pkg::*;

  port_word_t sync_q1;
  port_word_t sync_q2;

  // Two flops against metastability on async pad inputs
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= port_pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  assign port_sync_o = sync_q2;

  // Value only on output bits, input bits drive 0
  assign port_drive_o = cfg.gpio_out & cfg.gpio_dir;
  assign port_oe_o    = cfg.gpio_dir;

endmodule

`default_nettype wire

/* rtl/pad_mux.sv */
// Per-pad selection between PWM, UART and port drives, and pad input routing back to the ports
`timescale 1ns/100ps
`default_nettype none

module pad_mux #(
  parameter int PWM_NUM_P = pinmux_pkg::PWM_NUM
) (
  pinmux_cfg_if.mux              cfg,
  input  logic [PWM_NUM_P-1:0]   pwm_wave_i,
  input  pinmux_pkg::port_word_t port_drive_i,
  input  pinmux_pkg::port_word_t port_oe_i,
  input  logic                   uart_txd_i,
  input  pad_map_pkg::pad_vec_t  pad_in_i,
  output pad_map_pkg::pad_vec_t  pad_out_o,
  output pad_map_pkg::pad_vec_t  pad_oen_o,
  output logic                   uart_rxd_o,
  output pinmux_pkg::port_word_t port_pad_in_o
);
  import pinmux_pkg::*;
  import pad_map_pkg::*;

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  // Later assignments win, so lowest priority goes first
  always_comb begin
    // Idle pads are inputs driving 0
    pad_out_o = '0;
    pad_oen_o = '1;

    // Port direction
    for (int b = 0; b < $bits(port_word_t); b++) begin
      if (PORT_PAD[b] != PAD_NONE && port_oe_i[b]) begin
        pad_out_o[PORT_PAD[b]] = port_drive_i[b];
        pad_oen_o[PORT_PAD[b]] = 1'b0;
      end
    end

    // UART forces RXD to input
    if (cfg.uart_enb) begin
      pad_out_o[UART_RXD_PAD] = 1'b0;
      pad_oen_o[UART_RXD_PAD] = 1'b1;
      pad_out_o[UART_TXD_PAD] = uart_txd_i;
      pad_oen_o[UART_TXD_PAD] = 1'b0;
    end

    // PWM on top
    for (int c = 0; c < PWM_NUM_P; c++) begin
      if (cfg.pwm_enb[c]) begin
        pad_out_o[PWM_PAD[c]] = pwm_wave_i[c];
        pad_oen_o[PWM_PAD[c]] = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  // Ports always see their pad, whatever function owns it
  always_comb begin
    port_pad_in_o = '0;
    for (int b = 0; b < $bits(port_word_t); b++) begin
      if (PORT_PAD[b] != PAD_NONE) begin
        port_pad_in_o[b] = pad_in_i[PORT_PAD[b]];
      end
    end
  end

  // Held low while the UART is off
  assign uart_rxd_o = cfg.uart_enb & pad_in_i[UART_RXD_PAD];

endmodule

`default_nettype wire

/* rtl/pinmux_top.sv */
// Pin mux top level with plain bus and pad ports, instantiated by the chip or the testbench
`timescale 1ns/100ps
`default_nettype none

module pinmux_top #(
  parameter int US_PER_MS = 1000,
  parameter int PWM_NUM_P = pinmux_pkg::PWM_NUM
) (
  input  logic                   mclk_i,
  input  logic                   arst_n_i,
  // Register bus
  input  logic                   reg_cs_i,
  input  logic                   reg_wr_i,
  input  pinmux_pkg::reg_addr_t  reg_addr_i,
  input  pinmux_pkg::reg_data_t  reg_wdata_i,
  input  pinmux_pkg::reg_be_t    reg_be_i,
  output pinmux_pkg::reg_data_t  reg_rdata_o,
  output logic                   reg_ack_o,
  // Pads
  input  pad_map_pkg::pad_vec_t  pad_in_i,
  output pad_map_pkg::pad_vec_t  pad_out_o,
  output pad_map_pkg::pad_vec_t  pad_oen_o,
  // UART pin function
  input  logic                   uart_txd_i,
  output logic                   uart_rxd_o
);
  import pinmux_pkg::*;

  pinmux_cfg_if cfg_if ();

  logic [PWM_NUM_P-1:0] pwm_wave;
  port_word_t           port_drive;
  port_word_t           port_oe;
  port_word_t           port_pad_in;
  port_word_t           port_sync;

  pinmux_regs u_regs (
    .mclk_i      (mclk_i),
    .arst_n_i    (arst_n_i),
    .reg_cs_i    (reg_cs_i),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .gpio_in_i   (port_sync),
    .cfg         (cfg_if.regs)
  );

  // PWM and port run side by side, pad mux picks per pad
  pwm_bank #(.US_PER_MS(US_PER_MS), .PWM_NUM_P(PWM_NUM_P)) u_pwm_bank (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .cfg        (cfg_if.pwm),
    .pwm_wave_o (pwm_wave)
  );

  gpio_port u_gpio_port (
    .mclk_i        (mclk_i),
    .arst_n_i      (arst_n_i),
    .cfg           (cfg_if.port),
    .port_pad_in_i (port_pad_in),
    .port_sync_o   (port_sync),
    .port_drive_o  (port_drive),
    .port_oe_o     (port_oe)
  );

  pad_mux #(.PWM_NUM_P(PWM_NUM_P)) u_pad_mux (
    .cfg           (cfg_if.mux),
    .pwm_wave_i    (pwm_wave),
    .port_drive_i  (port_drive),
    .port_oe_i     (port_oe),
    .uart_txd_i    (uart_txd_i),
    .pad_in_i      (pad_in_i),
    .pad_out_o     (pad_out_o),
    .pad_oen_o     (pad_oen_o),
    .uart_rxd_o    (uart_rxd_o),
    .port_pad_in_o (port_pad_in)
  );

endmodule

`default_nettype wire

/* tb/pinmux_tb.sv */
// Directed testbench for the pin mux top level, run from compile.f with pinmux_tb as top
`timescale 1ns/100ps
`default_nettype none

module pinmux_tb;
  import pinmux_pkg::*;
  import pad_map_pkg::*;

  localparam int CLK_HALF      = 20;
  localparam int DRIVE_DLY     = 2;   // Input change after the rising edge
  localparam int US_PER_MS_TB  = 4;
  localparam int BUS_TIMEOUT   = 16;  // Cycles
  localparam int LEVEL_TIMEOUT = 400;

  logic       mclk_i;
  logic       arst_n_i;
  logic       reg_cs_i;
  logic       reg_wr_i;
  reg_addr_t  reg_addr_i;
  reg_data_t  reg_wdata_i;
  reg_be_t    reg_be_i;
  reg_data_t  reg_rdata_o;
  logic       reg_ack_o;
  pad_vec_t   pad_in_i;
  pad_vec_t   pad_out_o;
  pad_vec_t   pad_oen_o;
  logic       uart_txd_i;
  logic       uart_rxd_o;

  int    seed;
  int    err_cnt;
  int    chk_cnt;
  int    test_cnt;
  int    test_err_base;
  string cur_test;

  pinmux_top #(.US_PER_MS(US_PER_MS_TB)) u_pinmux_top (
    .mclk_i      (mclk_i),
    .arst_n_i    (arst_n_i),
    .reg_cs_i    (reg_cs_i),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .pad_in_i    (pad_in_i),
    .pad_out_o   (pad_out_o),
    .pad_oen_o   (pad_oen_o),
    .uart_txd_i  (uart_txd_i),
    .uart_rxd_o  (uart_rxd_o)
  );

  always #CLK_HALF mclk_i = ~mclk_i;

  // --------------------------------------------------------------------------
  // Bookkeeping and compare tasks
  // --------------------------------------------------------------------------
  task automatic start_test(input string name);
    cur_test = name;
    test_err_base = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == test_err_base) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  task automatic note_timeout(input string what);
    $display("test %s: timed out waiting for %s", cur_test, what);
    err_cnt++;
  endtask

  task automatic check_data(input string what, input reg_data_t exp, input reg_data_t act);
    chk_cnt++;
    if (act !== exp) begin
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_pads(input string what, input pad_vec_t exp, input pad_vec_t act);
    chk_cnt++;
    if (act !== exp) begin
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string what, input pwm_count_t exp, input pwm_count_t act);
    chk_cnt++;
    if (act !== exp) begin
      $display("error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      $display("error %s %s: expected %b, actual %b", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus and timing helpers returning at a rising edge plus DRIVE_DLY
  // --------------------------------------------------------------------------
  task automatic step(input int n);
    repeat (n) begin
      @(posedge mclk_i);
      #DRIVE_DLY;
    end
  endtask

  task automatic bus_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                            input reg_be_t be, output reg_data_t rdata);
    int waited;
    waited = 0;
    rdata = '0;
    reg_cs_i = 1'b1;
    reg_wr_i = wr;
    reg_addr_i = addr;
    reg_wdata_i = wdata;
    reg_be_i = be;
    do begin
      step(1);
      waited++;
    end while (!reg_ack_o && waited < BUS_TIMEOUT);
    if (!reg_ack_o) begin
      note_timeout("bus acknowledge");
    end else begin
      rdata = reg_rdata_o;
    end
    // Write commits on the edge that ends the ack cycle
    step(1);
    reg_cs_i = 1'b0;
    reg_wr_i = 1'b0;
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data, input reg_be_t be);
    reg_data_t unused;
    bus_access(1'b1, addr, data, be, unused);
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    bus_access(1'b0, addr, '0, '0, data);
  endtask

  task automatic read_compare(input reg_addr_t addr, input reg_data_t exp);
    reg_data_t act;
    bus_read(addr, act);
    check_data($sformatf("read %h", addr), exp, act);
  endtask

  // Byte lanes with enable taken from the new word
  function automatic reg_data_t merge_bytes(reg_data_t old_v, reg_data_t new_v, reg_be_t be);
    reg_data_t mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  task automatic wait_pad_level(input int pad, input logic lvl);
    int waited;
    waited = 0;
    while (pad_out_o[pad] !== lvl && waited < LEVEL_TIMEOUT) begin
      step(1);
      waited++;
    end
    if (pad_out_o[pad] !== lvl) begin
      note_timeout($sformatf("pad %0d at %b", pad, lvl));
    end
  endtask

  task automatic measure_level(input int pad, input logic lvl, output int cycles);
    cycles = 0;
    while (pad_out_o[pad] === lvl && cycles < LEVEL_TIMEOUT) begin
      cycles++;
      step(1);
    end
    if (cycles >= LEVEL_TIMEOUT) begin
      note_timeout($sformatf("pad %0d to leave %b", pad, lvl));
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_reset();
    start_test("reset");
    check_bit("reg_ack_o", 1'b0, reg_ack_o);
    check_pads("pad_oen_o", '1, pad_oen_o);
    check_pads("pad_out_o", '0, pad_out_o);
    check_bit("uart_rxd_o", 1'b0, uart_rxd_o);
    read_compare(ADDR_GPIO_OUT, '0);
    read_compare(ADDR_GPIO_DIR, '0);
    read_compare(ADDR_FUNC_SEL, '0);
    read_compare(ADDR_GPIO_IN, '0);
    read_compare(ADDR_US_DIV, '0);
    for (int c = 0; c < PWM_NUM; c++) begin
      read_compare(reg_addr_t'(ADDR_PWM_BASE + 4*c), '0);
    end
    end_test();
  endtask

  task automatic test_reg_access();
    reg_data_t model [7];
    reg_data_t data;
    reg_be_t   be;
    reg_addr_t addr;
    int        k;
    start_test("reg_access");
    // Slot 0 is GPIO_OUT, slots 1 to 6 the PWM words
    for (int i = 0; i < 7; i++) begin
      model[i] = '0;
    end
    for (int n = 0; n < 40; n++) begin
      k = {$random(seed)} % 7;
      data = $random(seed);
      be = reg_be_t'($random(seed));
      addr = (k == 0) ? ADDR_GPIO_OUT : reg_addr_t'(ADDR_PWM_BASE + 4*(k-1));
      bus_write(addr, data, be);
      model[k] = merge_bytes(model[k], data, be);
      read_compare(addr, model[k]);
    end
    // Holes, misaligned PWM slot and beyond the last channel
    bus_write(8'h14, 32'hffff_ffff, 4'hf);
    read_compare(8'h14, '0);
    read_compare(8'h1c, '0);
    read_compare(8'h22, '0);
    read_compare(8'h38, '0);
    read_compare(8'hfc, '0);
    end_test();
  endtask

  task automatic test_gpio_out();
    reg_data_t dir;
    reg_data_t val;
    pad_vec_t  exp_out;
    pad_vec_t  exp_oen;
    start_test("gpio_out");
    for (int n = 0; n < 6; n++) begin
      dir = $random(seed);
      val = $random(seed);
      bus_write(ADDR_GPIO_OUT, val, 4'hf);
      bus_write(ADDR_GPIO_DIR, dir, 4'hf);
      exp_out = '0;
      exp_oen = '1;
      for (int b = 0; b < 32; b++) begin
        if (PORT_PAD[b] != PAD_NONE && dir[b]) begin
          exp_out[PORT_PAD[b]] = val[b];
          exp_oen[PORT_PAD[b]] = 1'b0;
        end
      end
      check_pads("pad_out_o", exp_out, pad_out_o);
      check_pads("pad_oen_o", exp_oen, pad_oen_o);
      check_bit("pad 17 oen", 1'b1, pad_oen_o[17]);
    end
    bus_write(ADDR_GPIO_DIR, '0, 4'hf);
    end_test();
  endtask

  task automatic test_gpio_in();
    pad_vec_t  pads;
    reg_data_t exp;
    start_test("gpio_in");
    for (int n = 0; n < 6; n++) begin
      pads = pad_vec_t'($random(seed));
      pad_in_i = pads;
      step(3);
      exp = '0;
      for (int b = 0; b < 32; b++) begin
        if (PORT_PAD[b] != PAD_NONE) begin
          exp[b] = pads[PORT_PAD[b]];
        end
      end
      read_compare(ADDR_GPIO_IN, exp);
    end
    end_test();
  endtask

  task automatic test_pwm();
    int ch;
    int pad;
    int hi_len;
    int lo_len;
    int cyc_per_ms;
    pwm_count_t h;
    pwm_count_t l;
    start_test("pwm");
    ch = 3;
    pad = PWM_PAD[ch];
    h = 16'd2;
    l = 16'd3;
    // us_div of 1 gives two clocks per microsecond
    cyc_per_ms = 2 * US_PER_MS_TB;
    // Port drives every pad high underneath the PWM
    bus_write(ADDR_GPIO_OUT, '1, 4'hf);
    bus_write(ADDR_GPIO_DIR, '1, 4'hf);
    bus_write(ADDR_US_DIV, 32'd1, 4'hf);
    bus_write(reg_addr_t'(ADDR_PWM_BASE + 4*ch), {h, l}, 4'hf);
    bus_write(ADDR_FUNC_SEL, reg_data_t'(1) << ch, 4'hf);
    check_bit("pwm pad oen", 1'b0, pad_oen_o[pad]);
    // Skip into the second full period
    wait_pad_level(pad, 1'b1);
    wait_pad_level(pad, 1'b0);
    wait_pad_level(pad, 1'b1);
    check_bit("pwm pad oen high", 1'b0, pad_oen_o[pad]);
    measure_level(pad, 1'b1, hi_len);
    check_bit("pwm pad oen low", 1'b0, pad_oen_o[pad]);
    measure_level(pad, 1'b0, lo_len);
    check_count("high time", pwm_count_t'(h * cyc_per_ms), pwm_count_t'(hi_len));
    check_count("low time", pwm_count_t'(l * cyc_per_ms), pwm_count_t'(lo_len));
    // Port drive shows once the channel is off
    bus_write(ADDR_FUNC_SEL, '0, 4'hf);
    check_bit("port after pwm off", 1'b1, pad_out_o[pad]);
    bus_write(ADDR_GPIO_DIR, '0, 4'hf);
    bus_write(ADDR_GPIO_OUT, '0, 4'hf);
    bus_write(ADDR_US_DIV, '0, 4'hf);
    end_test();
  endtask

  task automatic test_uart();
    start_test("uart");
    // Port wants both UART pads as outputs driving 0
    bus_write(ADDR_GPIO_DIR, '1, 4'hf);
    pad_in_i = '0;
    uart_txd_i = 1'b1;
    bus_write(ADDR_FUNC_SEL, reg_data_t'(1) << FUNC_UART_BIT, 4'hf);
    check_bit("txd pad out", 1'b1, pad_out_o[UART_TXD_PAD]);
    check_bit("txd pad oen", 1'b0, pad_oen_o[UART_TXD_PAD]);
    check_bit("rxd pad oen", 1'b1, pad_oen_o[UART_RXD_PAD]);
    uart_txd_i = 1'b0;
    pad_in_i[UART_RXD_PAD] = 1'b1;
    step(1);
    check_bit("txd pad out", 1'b0, pad_out_o[UART_TXD_PAD]);
    check_bit("rxd high", 1'b1, uart_rxd_o);
    pad_in_i[UART_RXD_PAD] = 1'b0;
    step(1);
    check_bit("rxd low", 1'b0, uart_rxd_o);
    // Receive held low with the UART off
    pad_in_i[UART_RXD_PAD] = 1'b1;
    bus_write(ADDR_FUNC_SEL, '0, 4'hf);
    check_bit("rxd disabled", 1'b0, uart_rxd_o);
    check_bit("rxd pad oen port", 1'b0, pad_oen_o[UART_RXD_PAD]);
    bus_write(ADDR_GPIO_DIR, '0, 4'hf);
    end_test();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    seed = 32'hfe9a_159a;
    err_cnt = 0;
    chk_cnt = 0;
    test_cnt = 0;
    test_err_base = 0;
    cur_test = "";
    mclk_i = 1'b0;
    arst_n_i = 1'b0;
    reg_cs_i = 1'b0;
    reg_wr_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    reg_be_i = '0;
    pad_in_i = '0;
    uart_txd_i = 1'b0;
    step(4);
    arst_n_i = 1'b1;
    step(1);

    test_reset();
    test_reg_access();
    test_gpio_out();
    test_gpio_in();
    test_pwm();
    test_uart();

    $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/pinmux_pkg.sv
rtl/pad_map_pkg.sv
rtl/pinmux_cfg_if.sv
rtl/pinmux_regs.sv
rtl/tick_gen.sv
rtl/pwm_bank.sv
rtl/gpio_port.sv
rtl/pad_mux.sv
rtl/pinmux_top.sv
tb/pinmux_tb.sv
